// File: ooo_core.f
source/core_pkg.sv
source/mult_unit.sv
source/alu_stage.sv
source/reservation_station.sv
source/reorder_buffer.sv
source/dispatch_unit.sv
source/ooo_core.sv
verification/clock_gen.sv
verification/ooo_core_props.sv
verification/ooo_core_tb.sv

// File: Makefile
# Verilator build and run of the back-end testbench

TOP = ooo_core_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

# pass only if the log holds the pass line
test:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		-f ooo_core.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// File: verification/ooo_core_tb.sv
// testbench for the out-of-order back end
// random dispatch stream, in-order reference model, commit checks, timeout
`default_nettype none

module ooo_core_tb import core_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	// ops sent by tests 2 to 5 set the hang limit
	localparam int total_ops = 200 + 200 + 60 + 20;
	localparam int cycle_limit = total_ops * 20 + 200;

	logic clock, reset;
	logic dispatch_valid, dispatch_stall;
	op_t dispatch_op;
	logic [reg_idx_width-1:0] dispatch_rd, dispatch_rs1, dispatch_rs2;
	logic commit_valid;
	logic [reg_idx_width-1:0] commit_rd;
	logic [xlen-1:0] commit_data;

	// reference model with program-order registers and expected commits
	logic [xlen-1:0] model_regs [reg_count];
	logic [reg_idx_width-1:0] exp_rd_q [$];
	logic [xlen-1:0] exp_data_q [$];
	int seed = 32'hd087;
	int errors = 0;
	int checks = 0;
	int accepted = 0;
	int commits = 0;
	int cycle_count = 0;
	logic stall_seen = 1'b0;

	clock_gen clock_gen_inst (.clock(clock), .reset(reset));

	ooo_core ooo_core_inst (.*);

	// result of one op by the encoding rules
	function automatic logic [xlen-1:0] compute_result(
		input op_t op,
		input logic [xlen-1:0] a,
		input logic [xlen-1:0] b
	);
		case (op)
			op_add: return a + b;
			op_sub: return a - b;
			op_and: return a & b;
			op_or: return a | b;
			op_xor: return a ^ b;
			op_slt: return ($signed(a) < $signed(b)) ? xlen'(1) : xlen'(0);
			op_mul: return a * b;
			default: return '0;
		endcase
	endfunction

	// only registers 1 to 7 so the chains stay short
	function automatic logic [reg_idx_width-1:0] random_reg();
		return reg_idx_width'(1 + $unsigned($random(seed)) % 7);
	endfunction

	function automatic op_t random_alu_op();
		return op_t'(3'($unsigned($random(seed)) % 6));
	endfunction

	// holds the op from 1 ns after a rising edge until accepted
	task automatic send_op(
		input op_t op,
		input logic [reg_idx_width-1:0] rd,
		input logic [reg_idx_width-1:0] rs1,
		input logic [reg_idx_width-1:0] rs2
	);
		logic taken;
		logic [xlen-1:0] result;
		dispatch_valid = 1'b1;
		dispatch_op = op;
		dispatch_rd = rd;
		dispatch_rs1 = rs1;
		dispatch_rs2 = rs2;
		taken = 1'b0;
		while (!taken) begin
			// stall depends on state and op only and is stable by mid-cycle
			@(negedge clock);
			taken = !dispatch_stall;
			if (dispatch_stall)
				stall_seen = 1'b1;
			@(posedge clock);
			#1;
		end
		dispatch_valid = 1'b0;
		result = compute_result(op, model_regs[rs1], model_regs[rs2]);
		exp_rd_q.push_back(rd);
		exp_data_q.push_back(result);
		// x0 stays zero in the model
		if (rd != '0)
			model_regs[rd] = result;
		accepted++;
	endtask

	task automatic wait_drain();
		while (exp_rd_q.size() != 0) begin
			@(posedge clock);
			#1;
		end
	endtask

	task automatic report_test(input int num, input string name, input int errors_before);
		$display("test %0d %s: %0d errors", num, name, errors - errors_before);
	endtask

	////////////////////////////////////////
	// commit monitor and hang guard
	////////////////////////////////////////

	// outputs sampled mid-cycle once per commit pulse
	always @(negedge clock) begin
		logic [reg_idx_width-1:0] exp_rd;
		logic [xlen-1:0] exp_data;
		if (!reset && commit_valid) begin
			commits++;
			checks++;
			assert (exp_rd_q.size() != 0) else begin
				errors++;
				$display("commit at %0t with no operation outstanding", $time);
			end
			if (exp_rd_q.size() != 0) begin
				exp_rd = exp_rd_q.pop_front();
				exp_data = exp_data_q.pop_front();
				assert (commit_rd == exp_rd && commit_data == exp_data) else begin
					errors++;
					$display("FAILED %0t: commit rd %0d data %h, expected rd %0d data %h",
						$time, commit_rd, commit_data, exp_rd, exp_data);
				end
			end
		end
	end

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: the run hung after %0d cycles, %0d commits still pending",
				cycle_count, exp_rd_q.size());
			$display("Simulation failed");
			$finish;
		end
	end

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial begin
		int errors_before;
		logic [reg_idx_width-1:0] prev_rd, rd;
		dispatch_valid = 1'b0;
		dispatch_op = op_add;
		dispatch_rd = '0;
		dispatch_rs1 = '0;
		dispatch_rs2 = '0;
		for (int i = 0; i < reg_count; i++)
			model_regs[i] = '0;
		@(negedge reset);
		@(posedge clock);
		#1;

		// idle after reset
		errors_before = errors;
		repeat (10) begin
			@(negedge clock);
			checks++;
			assert (!commit_valid && !dispatch_stall) else begin
				errors++;
				$display("FAILED %0t: commit_valid %b dispatch_stall %b while idle",
					$time, commit_valid, dispatch_stall);
			end
		end
		@(posedge clock);
		#1;
		report_test(1, "idle after reset", errors_before);

		// dependent ALU chains
		errors_before = errors;
		repeat (200)
			send_op(random_alu_op(), random_reg(), random_reg(), random_reg());
		wait_drain();
		report_test(2, "alu chains", errors_before);

		// roughly one multiply in three
		errors_before = errors;
		repeat (200) begin
			if ($unsigned($random(seed)) % 3 == 0)
				send_op(op_mul, random_reg(), random_reg(), random_reg());
			else
				send_op(random_alu_op(), random_reg(), random_reg(), random_reg());
		end
		wait_drain();
		report_test(3, "mixed alu and mul", errors_before);

		// each multiply reads the previous destination
		errors_before = errors;
		stall_seen = 1'b0;
		prev_rd = reg_idx_width'(1);
		repeat (60) begin
			rd = random_reg();
			send_op(op_mul, rd, prev_rd, random_reg());
			prev_rd = rd;
		end
		wait_drain();
		checks++;
		assert (stall_seen) else begin
			errors++;
			$display("dispatch_stall never went high during the multiply burst");
		end
		report_test(4, "mul burst", errors_before);

		// writes to x0 followed by reads of x0
		errors_before = errors;
		repeat (10) begin
			if ($unsigned($random(seed)) % 2 == 0)
				send_op(op_mul, '0, random_reg(), random_reg());
			else
				send_op(random_alu_op(), '0, random_reg(), random_reg());
		end
		repeat (10)
			send_op(random_alu_op(), random_reg(), '0, random_reg());
		wait_drain();
		report_test(5, "register zero", errors_before);

		// everything accepted has retired
		errors_before = errors;
		checks++;
		assert (commits == accepted && !dispatch_stall) else begin
			errors++;
			$display("FAILED %0t: %0d commits for %0d accepted ops, stall %b",
				$time, commits, accepted, dispatch_stall);
		end
		report_test(6, "drain", errors_before);

		$display("summary: %0d ops, %0d commits, %0d checks, %0d errors",
			accepted, commits, checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/ooo_core_props.sv
// concurrent checks on the top-level ports of the back end
// bound into ooo_core below the module
`default_nettype none

module ooo_core_props import core_pkg::*; (
	input logic clock,
	input logic reset,
	input logic dispatch_stall,
	input logic commit_valid,
	input logic [reg_idx_width-1:0] commit_rd
);
	timeunit 1ns;
	timeprecision 100ps;

	// nothing retires straight out of reset
	assert property (@(posedge clock) reset |=> !commit_valid)
		else $error("commit_valid high in the cycle after reset");

	// state is cleared after the first reset edge, so stall must be low
	assert property (@(posedge clock) (reset && $past(reset)) |-> !dispatch_stall)
		else $error("dispatch_stall high while reset is asserted");

	// a retiring op always names a real register
	assert property (@(posedge clock) disable iff (reset)
		commit_valid |-> !$isunknown(commit_rd))
		else $error("commit_rd unknown during a commit");

endmodule

bind ooo_core ooo_core_props ooo_core_props_inst (
	.clock(clock),
	.reset(reset),
	.dispatch_stall(dispatch_stall),
	.commit_valid(commit_valid),
	.commit_rd(commit_rd)
);

`default_nettype wire

// File: verification/clock_gen.sv
// testbench clock and power-on reset
// 4 ns period, reset held for three rising edges
`default_nettype none

module clock_gen (
	output logic clock,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;

	initial clock = 1'b0;
	always #2 clock = ~clock;

	// release a little after the third edge, like the stimulus
	initial begin
		reset = 1'b1;
		repeat (3) @(posedge clock);
		#1;
		reset = 1'b0;
	end

endmodule

`default_nettype wire

// File: source/ooo_core.sv
// top level of the out-of-order back end
// dispatch, reorder buffer, two stations, ALU and multiplier on one CDB
`default_nettype none

module ooo_core import core_pkg::*; (
	input logic clock,
	input logic reset,
	input logic dispatch_valid,
	input op_t dispatch_op,
	input logic [reg_idx_width-1:0] dispatch_rd,
	input logic [reg_idx_width-1:0] dispatch_rs1,
	input logic [reg_idx_width-1:0] dispatch_rs2,
	output logic dispatch_stall,
	output logic commit_valid,
	output logic [reg_idx_width-1:0] commit_rd,
	output logic [xlen-1:0] commit_data
);

	// allocation and operand lookup
	logic rob_alloc, alu_alloc, mult_alloc;
	logic rob_full, alu_rs_full, mult_rs_full;
	logic [rob_tag_width-1:0] alloc_tag, commit_tag;
	logic [rob_tag_width-1:0] rs1_tag, rs2_tag;
	logic rob_rs1_ready, rob_rs2_ready;
	logic [xlen-1:0] rob_rs1_value, rob_rs2_value;
	logic op_rs1_ready, op_rs2_ready;
	logic [xlen-1:0] op_rs1_value_or_tag, op_rs2_value_or_tag;

	// station issue
	logic alu_issue_valid, mult_issue_valid, alu_busy;
	op_t alu_issue_op;
	logic [rob_tag_width-1:0] alu_issue_tag, mult_issue_tag;
	logic [xlen-1:0] alu_issue_a, alu_issue_b, mult_issue_a, mult_issue_b;

	// multiplier result and the shared bus
	logic mult_valid, cdb_valid;
	logic [rob_tag_width-1:0] mult_tag, cdb_tag;
	logic [xlen-1:0] mult_value, cdb_value;

	////////////////////////////////////////
	// in-order front: rename and rob
	////////////////////////////////////////

	dispatch_unit dispatch_unit_inst (.*);

	reorder_buffer reorder_buffer_inst (.*);

	////////////////////////////////////////
	// stations and execution
	////////////////////////////////////////

	reservation_station alu_rs (
		.*,
		.alloc(alu_alloc),
		.exec_busy(alu_busy),
		.full(alu_rs_full),
		.issue_valid(alu_issue_valid),
		.issue_op(alu_issue_op),
		.issue_tag(alu_issue_tag),
		.issue_a(alu_issue_a),
		.issue_b(alu_issue_b)
	);

	// multiplier never stalls, so its station is never held
	reservation_station mult_rs (
		.*,
		.alloc(mult_alloc),
		.exec_busy(1'b0),
		.full(mult_rs_full),
		.issue_valid(mult_issue_valid),
		.issue_op(),
		.issue_tag(mult_issue_tag),
		.issue_a(mult_issue_a),
		.issue_b(mult_issue_b)
	);

	alu_stage alu_stage_inst (
		.*,
		.issue_valid(alu_issue_valid),
		.issue_op(alu_issue_op),
		.issue_tag(alu_issue_tag),
		.issue_a(alu_issue_a),
		.issue_b(alu_issue_b)
	);

	mult_unit mult_unit_inst (
		.*,
		.issue_valid(mult_issue_valid),
		.issue_tag(mult_issue_tag),
		.issue_a(mult_issue_a),
		.issue_b(mult_issue_b)
	);

endmodule

`default_nettype wire

// File: source/dispatch_unit.sv
// rename map table and architectural register file
// operand lookup with rob and cdb bypass, dispatch stall and allocation
`default_nettype none

module dispatch_unit import core_pkg::*; (
	input logic clock,
	input logic reset,
	input logic dispatch_valid,
	input op_t dispatch_op,
	input logic [reg_idx_width-1:0] dispatch_rd,
	input logic [reg_idx_width-1:0] dispatch_rs1,
	input logic [reg_idx_width-1:0] dispatch_rs2,
	input logic rob_full,
	input logic alu_rs_full,
	input logic mult_rs_full,
	input logic [rob_tag_width-1:0] alloc_tag,
	input logic rob_rs1_ready,
	input logic [xlen-1:0] rob_rs1_value,
	input logic rob_rs2_ready,
	input logic [xlen-1:0] rob_rs2_value,
	input logic cdb_valid,
	input logic [rob_tag_width-1:0] cdb_tag,
	input logic [xlen-1:0] cdb_value,
	input logic commit_valid,
	input logic [reg_idx_width-1:0] commit_rd,
	input logic [xlen-1:0] commit_data,
	input logic [rob_tag_width-1:0] commit_tag,
	output logic dispatch_stall,
	output logic rob_alloc,
	output logic alu_alloc,
	output logic mult_alloc,
	output logic [rob_tag_width-1:0] rs1_tag,
	output logic [rob_tag_width-1:0] rs2_tag,
	output logic op_rs1_ready,
	output logic [xlen-1:0] op_rs1_value_or_tag,
	output logic op_rs2_ready,
	output logic [xlen-1:0] op_rs2_value_or_tag
);

	// map: register -> producing rob tag
	logic [reg_count-1:0] map_valid;
	logic [rob_tag_width-1:0] map_tag [reg_count];
	logic [xlen-1:0] regfile [reg_count];
	logic is_mul;

	// one source operand, returns {ready, value or tag}
	function automatic logic [xlen:0] resolve(
		input logic [reg_idx_width-1:0] rs,
		input logic rob_ready,
		input logic [xlen-1:0] rob_value
	);
		if (rs == '0)
			return {1'b1, xlen'(0)};
		// committed value in the register file
		if (!map_valid[rs])
			return {1'b1, regfile[rs]};
		// producer done, waiting in the rob
		if (rob_ready)
			return {1'b1, rob_value};
		// producer on the bus this very cycle
		if (cdb_valid && cdb_tag == map_tag[rs])
			return {1'b1, cdb_value};
		return {1'b0, xlen'(map_tag[rs])};
	endfunction

	// the rob reads its entries with the mapped tags
	assign rs1_tag = map_tag[dispatch_rs1];
	assign rs2_tag = map_tag[dispatch_rs2];

	assign {op_rs1_ready, op_rs1_value_or_tag} = resolve(dispatch_rs1, rob_rs1_ready, rob_rs1_value);
	assign {op_rs2_ready, op_rs2_value_or_tag} = resolve(dispatch_rs2, rob_rs2_ready, rob_rs2_value);

	////////////////////////////////////////
	// stall and allocation
	////////////////////////////////////////

	// stall looks only at state and the op, never at valid
	assign is_mul = dispatch_op == op_mul;
	assign dispatch_stall = rob_full | (is_mul ? mult_rs_full : alu_rs_full);
	assign rob_alloc = dispatch_valid & ~dispatch_stall;
	assign alu_alloc = rob_alloc & ~is_mul;
	assign mult_alloc = rob_alloc & is_mul;

	always_ff @(posedge clock) begin
		if (reset) begin
			map_valid <= '0;
			for (int i = 0; i < reg_count; i++)
				regfile[i] <= '0;
		end else begin
			// commit, x0 is never written
			if (commit_valid && commit_rd != '0) begin
				regfile[commit_rd] <= commit_data;
				// drop the mapping only if no younger op renamed it
				if (map_valid[commit_rd] && map_tag[commit_rd] == commit_tag)
					map_valid[commit_rd] <= 1'b0;
			end
			// a new rename wins over the clear above
			if (rob_alloc && dispatch_rd != '0) begin
				map_valid[dispatch_rd] <= 1'b1;
				map_tag[dispatch_rd] <= alloc_tag;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/reorder_buffer.sv
// circular reorder buffer
// in-order allocation, cdb writeback, operand reads and in-order commit
`default_nettype none

module reorder_buffer import core_pkg::*; (
	input logic clock,
	input logic reset,
	input logic rob_alloc,
	input logic [reg_idx_width-1:0] dispatch_rd,
	input logic [rob_tag_width-1:0] rs1_tag,
	input logic [rob_tag_width-1:0] rs2_tag,
	input logic cdb_valid,
	input logic [rob_tag_width-1:0] cdb_tag,
	input logic [xlen-1:0] cdb_value,
	output logic rob_full,
	output logic [rob_tag_width-1:0] alloc_tag,
	output logic rob_rs1_ready,
	output logic [xlen-1:0] rob_rs1_value,
	output logic rob_rs2_ready,
	output logic [xlen-1:0] rob_rs2_value,
	output logic commit_valid,
	output logic [reg_idx_width-1:0] commit_rd,
	output logic [xlen-1:0] commit_data,
	output logic [rob_tag_width-1:0] commit_tag
);

	// entry payload
	logic [reg_idx_width-1:0] rd_q [rob_depth];
	logic [xlen-1:0] value_q [rob_depth];
	logic [rob_depth-1:0] done_q;

	// pointers and occupancy
	logic [rob_tag_width-1:0] head, tail;
	logic [rob_tag_width:0] count;

	assign rob_full = count == (rob_tag_width + 1)'(rob_depth);
	assign alloc_tag = tail;

	// operand reads for dispatch
	assign rob_rs1_ready = done_q[rs1_tag];
	assign rob_rs1_value = value_q[rs1_tag];
	assign rob_rs2_ready = done_q[rs2_tag];
	assign rob_rs2_value = value_q[rs2_tag];

	// head retires one cycle after its cdb edge at the earliest
	assign commit_valid = (count != '0) && done_q[head];
	assign commit_rd = rd_q[head];
	assign commit_data = value_q[head];
	assign commit_tag = head;

	////////////////////////////////////////
	// control state
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			done_q <= '0;
		end else begin
			if (rob_alloc) begin
				done_q[tail] <= 1'b0;
				tail <= tail + rob_tag_width'(1);
			end
			// bus tags only name allocated entries, never the tail
			if (cdb_valid)
				done_q[cdb_tag] <= 1'b1;
			if (commit_valid)
				head <= head + rob_tag_width'(1);
			count <= count + (rob_tag_width + 1)'(rob_alloc)
				- (rob_tag_width + 1)'(commit_valid);
		end
	end

	// payload
	always_ff @(posedge clock) begin
		if (rob_alloc)
			rd_q[tail] <= dispatch_rd;
		if (cdb_valid)
			value_q[cdb_tag] <= cdb_value;
	end

endmodule

`default_nettype wire

// File: source/reservation_station.sv
// reservation station with cdb snooping
// entries kept compacted in age order, oldest ready entry issues first
`default_nettype none

module reservation_station import core_pkg::*; (
	input logic clock,
	input logic reset,
	input logic alloc,
	input op_t dispatch_op,
	input logic [rob_tag_width-1:0] alloc_tag,
	input logic op_rs1_ready,
	input logic [xlen-1:0] op_rs1_value_or_tag,
	input logic op_rs2_ready,
	input logic [xlen-1:0] op_rs2_value_or_tag,
	input logic cdb_valid,
	input logic [rob_tag_width-1:0] cdb_tag,
	input logic [xlen-1:0] cdb_value,
	input logic exec_busy,
	output logic full,
	output logic issue_valid,
	output op_t issue_op,
	output logic [rob_tag_width-1:0] issue_tag,
	output logic [xlen-1:0] issue_a,
	output logic [xlen-1:0] issue_b
);

	// entry 0 is the oldest, entries at and above count are empty
	op_t op_q [rs_depth];
	logic [rob_tag_width-1:0] tag_q [rs_depth];
	logic [rs_depth-1:0] a_rdy, b_rdy, a_rdy_s, b_rdy_s;
	logic [xlen-1:0] a_val [rs_depth], b_val [rs_depth];
	logic [xlen-1:0] a_val_s [rs_depth], b_val_s [rs_depth];
	logic [rs_idx_width:0] count, keep_count;
	logic [rs_idx_width-1:0] issue_idx;
	logic issue_found;

	// a waiting operand holds its tag in the low bits
	function automatic logic [xlen:0] snoop(input logic rdy, input logic [xlen-1:0] val);
		if (!rdy && cdb_valid && cdb_tag == val[rob_tag_width-1:0])
			return {1'b1, cdb_value};
		return {rdy, val};
	endfunction

	always_comb begin
		for (int i = 0; i < rs_depth; i++) begin
			{a_rdy_s[i], a_val_s[i]} = snoop(a_rdy[i], a_val[i]);
			{b_rdy_s[i], b_val_s[i]} = snoop(b_rdy[i], b_val[i]);
		end
	end

	// registered ready flags, so issue comes a cycle after capture
	always_comb begin
		issue_found = 1'b0;
		issue_idx = '0;
		for (int i = rs_depth - 1; i >= 0; i--) begin
			if ((rs_idx_width + 1)'(i) < count && a_rdy[i] && b_rdy[i]) begin
				issue_found = 1'b1;
				issue_idx = rs_idx_width'(i);
			end
		end
	end

	assign issue_valid = issue_found & ~exec_busy;
	assign issue_op = op_q[issue_idx];
	assign issue_tag = tag_q[issue_idx];
	assign issue_a = a_val[issue_idx];
	assign issue_b = b_val[issue_idx];
	assign full = count == (rs_idx_width + 1)'(rs_depth);
	assign keep_count = count - (rs_idx_width + 1)'(issue_valid);

	always_ff @(posedge clock) begin
		logic [rs_idx_width-1:0] src;
		if (reset)
			count <= '0;
		else
			count <= keep_count + (rs_idx_width + 1)'(alloc);
		// close the gap left by the issued entry
		for (int i = 0; i < rs_depth; i++) begin
			src = rs_idx_width'(i);
			if (issue_valid && src >= issue_idx && i < rs_depth - 1)
				src = rs_idx_width'(i + 1);
			op_q[i] <= op_q[src];
			tag_q[i] <= tag_q[src];
			{a_rdy[i], a_val[i]} <= {a_rdy_s[src], a_val_s[src]};
			{b_rdy[i], b_val[i]} <= {b_rdy_s[src], b_val_s[src]};
		end
		// new entry lands behind the survivors
		if (alloc) begin
			op_q[keep_count[rs_idx_width-1:0]] <= dispatch_op;
			tag_q[keep_count[rs_idx_width-1:0]] <= alloc_tag;
			a_rdy[keep_count[rs_idx_width-1:0]] <= op_rs1_ready;
			a_val[keep_count[rs_idx_width-1:0]] <= op_rs1_value_or_tag;
			b_rdy[keep_count[rs_idx_width-1:0]] <= op_rs2_ready;
			b_val[keep_count[rs_idx_width-1:0]] <= op_rs2_value_or_tag;
		end
	end

endmodule

`default_nettype wire

// File: source/alu_stage.sv
// single-cycle ALU with its result register
// drives the cdb, multiplier results take priority over a held ALU result
`default_nettype none

module alu_stage import core_pkg::*; (
	input logic clock,
	input logic reset,
	input logic issue_valid,
	input op_t issue_op,
	input logic [rob_tag_width-1:0] issue_tag,
	input logic [xlen-1:0] issue_a,
	input logic [xlen-1:0] issue_b,
	input logic mult_valid,
	input logic [rob_tag_width-1:0] mult_tag,
	input logic [xlen-1:0] mult_value,
	output logic alu_busy,
	output logic cdb_valid,
	output logic [rob_tag_width-1:0] cdb_tag,
	output logic [xlen-1:0] cdb_value
);

	logic [xlen-1:0] alu_result, res_value;
	logic [rob_tag_width-1:0] res_tag;
	logic res_valid;

	always_comb begin
		case (issue_op)
			op_add: alu_result = issue_a + issue_b;
			op_sub: alu_result = issue_a - issue_b;
			op_and: alu_result = issue_a & issue_b;
			op_or: alu_result = issue_a | issue_b;
			op_xor: alu_result = issue_a ^ issue_b;
			op_slt: alu_result = xlen'($signed(issue_a) < $signed(issue_b));
			default: alu_result = '0;
		endcase
	end

	// result stays unsent only while the multiplier owns the bus
	assign alu_busy = res_valid & mult_valid;

	always_ff @(posedge clock) begin
		if (reset)
			res_valid <= 1'b0;
		else
			res_valid <= issue_valid | alu_busy;
		// station does not issue while busy, so no overwrite
		if (issue_valid) begin
			res_tag <= issue_tag;
			res_value <= alu_result;
		end
	end

	// shared bus
	assign cdb_valid = mult_valid | res_valid;
	assign cdb_tag = mult_valid ? mult_tag : res_tag;
	assign cdb_value = mult_valid ? mult_value : res_value;

endmodule

`default_nettype wire

// File: source/mult_unit.sv
// pipelined multiplier consuming one operand chunk per stage
// tags and valids travel alongside the partial product
`default_nettype none

module mult_unit import core_pkg::*; (
	input logic clock,
	input logic reset,
	input logic issue_valid,
	input logic [rob_tag_width-1:0] issue_tag,
	input logic [xlen-1:0] issue_a,
	input logic [xlen-1:0] issue_b,
	output logic mult_valid,
	output logic [rob_tag_width-1:0] mult_tag,
	output logic [xlen-1:0] mult_value
);

	logic [mult_stages-1:0] valid_q;
	logic [rob_tag_width-1:0] tag_q [mult_stages];
	logic [xlen-1:0] prod_q [mult_stages];
	// shifted multiplicand and remaining multiplier bits
	logic [xlen-1:0] a_q [mult_stages-1], b_q [mult_stages-1];

	always_ff @(posedge clock) begin
		if (reset)
			valid_q <= '0;
		else
			valid_q <= {valid_q[mult_stages-2:0], issue_valid};
		// first stage takes the low chunk of b
		tag_q[0] <= issue_tag;
		prod_q[0] <= issue_a * xlen'(issue_b[mult_chunk-1:0]);
		a_q[0] <= issue_a << mult_chunk;
		b_q[0] <= issue_b >> mult_chunk;
		for (int i = 1; i < mult_stages; i++) begin
			tag_q[i] <= tag_q[i-1];
			prod_q[i] <= prod_q[i-1] + a_q[i-1] * xlen'(b_q[i-1][mult_chunk-1:0]);
		end
		for (int i = 1; i < mult_stages - 1; i++) begin
			a_q[i] <= a_q[i-1] << mult_chunk;
			b_q[i] <= b_q[i-1] >> mult_chunk;
		end
	end

	assign mult_valid = valid_q[mult_stages-1];
	assign mult_tag = tag_q[mult_stages-1];
	assign mult_value = prod_q[mult_stages-1];

endmodule

`default_nettype wire

// File: source/core_pkg.sv
// shared widths and buffer sizes for the back end
// operation encoding carried from dispatch to the execution units
`default_nettype none

package core_pkg;

	// datapath and register file
	localparam int xlen = 32;
	localparam int reg_count = 32;
	localparam int reg_idx_width = 5;

	// reorder buffer, power of two so pointers wrap on their own
	localparam int rob_depth = 8;
	localparam int rob_tag_width = 3;

	// each reservation station
	localparam int rs_depth = 4;
	localparam int rs_idx_width = 2;

	// multiplier latency and operand bits consumed per stage
	localparam int mult_stages = 3;
	localparam int mult_chunk = 11;

	// decoded operation
	typedef enum logic [2:0] {
		op_add = 3'd0,
		op_sub = 3'd1,
		op_and = 3'd2,
		op_or  = 3'd3,
		op_xor = 3'd4,
		// signed compare, result is 0 or 1
		op_slt = 3'd5,
		// low half of the product
		op_mul = 3'd6
	} op_t;

endpackage

`default_nettype wire
